//--- verilog/manycore_pkg.sv
/* Shared mesh definitions: grid size, edge coordinates, link field widths,
   packet field positions, vector typedefs and the router port enum. */
package manycore_pkg;

  localparam int NUM_TILES_X = 2;
  localparam int NUM_TILES_Y = 2; // I/O row sits at y = NUM_TILES_Y.
  localparam int DMEM_WORDS  = 16;
  localparam int NUM_DIRS    = 5;

  localparam int X_CORD_W = 1;
  localparam int Y_CORD_W = 2;
  localparam int ADDR_W   = 4;
  localparam int DATA_W   = 16;
  localparam int PKT_W    = 1 + ADDR_W + DATA_W + 2 * (X_CORD_W + Y_CORD_W);

  typedef logic [X_CORD_W-1:0] x_cord_t;
  typedef logic [Y_CORD_W-1:0] y_cord_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [PKT_W-1:0]    packet_t;

  // Op sits at the top, source row at the bottom.
  localparam int SRC_Y_LSB = 0;
  localparam int SRC_X_LSB = SRC_Y_LSB + Y_CORD_W;
  localparam int DST_Y_LSB = SRC_X_LSB + X_CORD_W;
  localparam int DST_X_LSB = DST_Y_LSB + Y_CORD_W;
  localparam int DATA_LSB  = DST_X_LSB + X_CORD_W;
  localparam int ADDR_LSB  = DATA_LSB + DATA_W;
  localparam int OP_LSB    = ADDR_LSB + ADDR_W;

  localparam logic OP_STORE = 1'b0;
  localparam logic OP_LOAD  = 1'b1;

  localparam x_cord_t CACHE_X  = '0;
  localparam y_cord_t CACHE_Y  = y_cord_t'(NUM_TILES_Y);
  localparam x_cord_t LOADER_X = x_cord_t'(NUM_TILES_X - 1);
  localparam y_cord_t LOADER_Y = y_cord_t'(NUM_TILES_Y);

  // Values double as bit positions in the router's port vectors.
  typedef enum logic [2:0] {P = 3'd0, N = 3'd1, S = 3'd2, E = 3'd3, W = 3'd4} dir_e;

endpackage

//--- verilog/mesh_router.sv
/* Five-port XY mesh router with one-entry input buffers
   and fixed-priority output arbitration (P, N, S, E, W). */
`timescale 1ns/10ps

module mesh_router #(
  parameter int my_x_p = 0,
  parameter int my_y_p = 0
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  p_v_i,
  input  manycore_pkg::packet_t p_pkt_i,
  output logic                  p_ready_o,
  output logic                  p_v_o,
  output manycore_pkg::packet_t p_pkt_o,
  input  logic                  p_ready_i,
  input  logic                  n_v_i,
  input  manycore_pkg::packet_t n_pkt_i,
  output logic                  n_ready_o,
  output logic                  n_v_o,
  output manycore_pkg::packet_t n_pkt_o,
  input  logic                  n_ready_i,
  input  logic                  s_v_i,
  input  manycore_pkg::packet_t s_pkt_i,
  output logic                  s_ready_o,
  output logic                  s_v_o,
  output manycore_pkg::packet_t s_pkt_o,
  input  logic                  s_ready_i,
  input  logic                  e_v_i,
  input  manycore_pkg::packet_t e_pkt_i,
  output logic                  e_ready_o,
  output logic                  e_v_o,
  output manycore_pkg::packet_t e_pkt_o,
  input  logic                  e_ready_i,
  input  logic                  w_v_i,
  input  manycore_pkg::packet_t w_pkt_i,
  output logic                  w_ready_o,
  output logic                  w_v_o,
  output manycore_pkg::packet_t w_pkt_o,
  input  logic                  w_ready_i
);

  logic [manycore_pkg::NUM_DIRS-1:0]                  in_v;
  logic [manycore_pkg::NUM_DIRS-1:0]                  in_ready;
  logic [manycore_pkg::NUM_DIRS-1:0]                  out_v;
  logic [manycore_pkg::NUM_DIRS-1:0]                  out_ready;
  logic [manycore_pkg::NUM_DIRS-1:0]                  buf_v;
  logic [manycore_pkg::NUM_DIRS-1:0]                  leave;
  manycore_pkg::packet_t [manycore_pkg::NUM_DIRS-1:0] in_pkt;
  manycore_pkg::packet_t [manycore_pkg::NUM_DIRS-1:0] out_pkt;
  manycore_pkg::packet_t [manycore_pkg::NUM_DIRS-1:0] buf_pkt;
  // Indexed [output][input].
  logic [manycore_pkg::NUM_DIRS-1:0][manycore_pkg::NUM_DIRS-1:0] req;
  logic [manycore_pkg::NUM_DIRS-1:0][manycore_pkg::NUM_DIRS-1:0] gnt;
  logic [manycore_pkg::NUM_DIRS-1:0][manycore_pkg::NUM_DIRS-1:0] hold_q;

  function automatic manycore_pkg::dir_e route_f(manycore_pkg::packet_t pkt);
    manycore_pkg::x_cord_t dst_x;
    manycore_pkg::y_cord_t dst_y;
    dst_x = pkt[manycore_pkg::DST_X_LSB +: manycore_pkg::X_CORD_W];
    dst_y = pkt[manycore_pkg::DST_Y_LSB +: manycore_pkg::Y_CORD_W];
    if (dst_x < my_x_p)
      route_f = manycore_pkg::W;
    else if (dst_x > my_x_p)
      route_f = manycore_pkg::E;
    else if (dst_y < my_y_p)
      route_f = manycore_pkg::N;
    else if (dst_y > my_y_p)
      route_f = manycore_pkg::S;
    else
      route_f = manycore_pkg::P;
  endfunction

  // Only packets injected from the south edge turn from Y into X.
  // Masking the other turns keeps the ready paths free of loops.
  function automatic logic legal_f(int in_d, int out_d);
    logic vert_in;
    logic horz_out;
    logic edge_in;
    vert_in  = (in_d == manycore_pkg::N) || (in_d == manycore_pkg::S);
    horz_out = (out_d == manycore_pkg::E) || (out_d == manycore_pkg::W);
    edge_in  = (in_d == manycore_pkg::S) && (my_y_p == manycore_pkg::NUM_TILES_Y - 1);
    legal_f  = (in_d != out_d) && !(vert_in && horz_out && !edge_in);
  endfunction

  assign in_v      = {w_v_i, e_v_i, s_v_i, n_v_i, p_v_i};
  assign in_pkt    = {w_pkt_i, e_pkt_i, s_pkt_i, n_pkt_i, p_pkt_i};
  assign out_ready = {w_ready_i, e_ready_i, s_ready_i, n_ready_i, p_ready_i};
  assign {w_ready_o, e_ready_o, s_ready_o, n_ready_o, p_ready_o} = in_ready;
  assign {w_v_o, e_v_o, s_v_o, n_v_o, p_v_o}                     = out_v;
  assign {w_pkt_o, e_pkt_o, s_pkt_o, n_pkt_o, p_pkt_o}           = out_pkt;

  always_comb begin
    for (int o = 0; o < manycore_pkg::NUM_DIRS; o++) begin
      for (int i = 0; i < manycore_pkg::NUM_DIRS; i++) begin
        req[o][i] = buf_v[i] && (int'(route_f(buf_pkt[i])) == o) && legal_f(i, o);
      end
    end
  end

  always_comb begin : arb
    logic taken;
    for (int o = 0; o < manycore_pkg::NUM_DIRS; o++) begin
      taken = 1'b0;
      for (int i = 0; i < manycore_pkg::NUM_DIRS; i++) begin
        gnt[o][i] = (|hold_q[o]) ? hold_q[o][i] : (req[o][i] && !taken); // Stalled grant sticks.
        taken     = taken || req[o][i];
      end
      out_v[o]   = |gnt[o];
      out_pkt[o] = '0;
      for (int i = 0; i < manycore_pkg::NUM_DIRS; i++) begin
        if (gnt[o][i])
          out_pkt[o] = buf_pkt[i];
      end
    end
  end

  always_comb begin
    leave = '0;
    for (int o = 0; o < manycore_pkg::NUM_DIRS; o++) begin
      for (int i = 0; i < manycore_pkg::NUM_DIRS; i++) begin
        if (gnt[o][i] && out_ready[o])
          leave[i] = 1'b1;
      end
    end
  end

  assign in_ready = ~buf_v | leave; // Slot reusable on the leaving edge.

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_v  <= '0;
      hold_q <= '0;
    end else begin
      for (int d = 0; d < manycore_pkg::NUM_DIRS; d++) begin
        if (in_v[d] && in_ready[d])
          buf_v[d] <= 1'b1;
        else if (leave[d])
          buf_v[d] <= 1'b0;
        hold_q[d] <= (out_v[d] && !out_ready[d]) ? gnt[d] : '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int d = 0; d < manycore_pkg::NUM_DIRS; d++) begin
      if (in_v[d] && in_ready[d])
        buf_pkt[d] <= in_pkt[d];
    end
  end

endmodule

//--- verilog/tile_endpoint.sv
/* Tile data memory endpoint.
   Executes stores and loads, returns a registered load response. */
`timescale 1ns/10ps

module tile_endpoint #(
  parameter int my_x_p = 0,
  parameter int my_y_p = 0
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_v_i,
  input  manycore_pkg::packet_t req_pkt_i,
  output logic                  req_ready_o,
  output logic                  resp_v_o,
  output manycore_pkg::packet_t resp_pkt_o,
  input  logic                  resp_ready_i
);

  manycore_pkg::data_t   mem_r [manycore_pkg::DMEM_WORDS];
  logic                  resp_v_r;
  manycore_pkg::packet_t resp_pkt_r;
  logic                  req_fire;
  logic                  req_op;
  manycore_pkg::addr_t   req_addr;
  manycore_pkg::data_t   req_data;
  manycore_pkg::x_cord_t req_src_x;
  manycore_pkg::y_cord_t req_src_y;

  assign req_op    = req_pkt_i[manycore_pkg::OP_LSB];
  assign req_addr  = req_pkt_i[manycore_pkg::ADDR_LSB +: manycore_pkg::ADDR_W];
  assign req_data  = req_pkt_i[manycore_pkg::DATA_LSB +: manycore_pkg::DATA_W];
  assign req_src_x = req_pkt_i[manycore_pkg::SRC_X_LSB +: manycore_pkg::X_CORD_W];
  assign req_src_y = req_pkt_i[manycore_pkg::SRC_Y_LSB +: manycore_pkg::Y_CORD_W];

  assign req_ready_o = !resp_v_r; // Blocked while a response waits.
  assign req_fire    = req_v_i && req_ready_o;
  assign resp_v_o    = resp_v_r;
  assign resp_pkt_o  = resp_pkt_r;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < manycore_pkg::DMEM_WORDS; i++) begin
        mem_r[i] <= '0;
      end
    end else if (req_fire && req_op == manycore_pkg::OP_STORE) begin
      mem_r[req_addr] <= req_data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)
      resp_v_r <= 1'b0;
    else if (req_fire && req_op == manycore_pkg::OP_LOAD)
      resp_v_r <= 1'b1;
    else if (resp_ready_i)
      resp_v_r <= 1'b0;
  end

  // Response goes back to the requester, tagged with this tile.
  always_ff @(posedge clk_i) begin
    if (req_fire && req_op == manycore_pkg::OP_LOAD) begin
      resp_pkt_r[manycore_pkg::OP_LSB]                               <= manycore_pkg::OP_LOAD;
      resp_pkt_r[manycore_pkg::ADDR_LSB +: manycore_pkg::ADDR_W]     <= req_addr;
      resp_pkt_r[manycore_pkg::DATA_LSB +: manycore_pkg::DATA_W]     <= mem_r[req_addr];
      resp_pkt_r[manycore_pkg::DST_X_LSB +: manycore_pkg::X_CORD_W]  <= req_src_x;
      resp_pkt_r[manycore_pkg::DST_Y_LSB +: manycore_pkg::Y_CORD_W]  <= req_src_y;
      resp_pkt_r[manycore_pkg::SRC_X_LSB +: manycore_pkg::X_CORD_W]  <=
        manycore_pkg::x_cord_t'(my_x_p);
      resp_pkt_r[manycore_pkg::SRC_Y_LSB +: manycore_pkg::Y_CORD_W]  <=
        manycore_pkg::y_cord_t'(my_y_p);
    end
  end

endmodule

//--- verilog/manycore_array.sv
/* Grid of routers and tile endpoints.
   Mesh wiring, north/east/west tie-offs, south edge brought out per column. */
`timescale 1ns/10ps

module manycore_array (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic                  [manycore_pkg::NUM_TILES_X-1:0] ver_s_v_i,
  input  manycore_pkg::packet_t [manycore_pkg::NUM_TILES_X-1:0] ver_s_pkt_i,
  output logic                  [manycore_pkg::NUM_TILES_X-1:0] ver_s_ready_o,
  output logic                  [manycore_pkg::NUM_TILES_X-1:0] ver_s_v_o,
  output manycore_pkg::packet_t [manycore_pkg::NUM_TILES_X-1:0] ver_s_pkt_o,
  input  logic                  [manycore_pkg::NUM_TILES_X-1:0] ver_s_ready_i
);

  localparam int NX = manycore_pkg::NUM_TILES_X;
  localparam int NY = manycore_pkg::NUM_TILES_Y;

  // Links by boundary. eg/wg run east/west, sg/ng run south/north.
  logic                  eg_v   [NY][NX+1];
  logic                  eg_rdy [NY][NX+1];
  manycore_pkg::packet_t eg_pkt [NY][NX+1];
  logic                  wg_v   [NY][NX+1];
  logic                  wg_rdy [NY][NX+1];
  manycore_pkg::packet_t wg_pkt [NY][NX+1];
  logic                  sg_v   [NY+1][NX];
  logic                  sg_rdy [NY+1][NX];
  manycore_pkg::packet_t sg_pkt [NY+1][NX];
  logic                  ng_v   [NY+1][NX];
  logic                  ng_rdy [NY+1][NX];
  manycore_pkg::packet_t ng_pkt [NY+1][NX];

  for (genvar y = 0; y < NY; y++) begin : g_hor_edge
    assign eg_v[y][0]    = 1'b0; // West edge.
    assign eg_pkt[y][0]  = '0;
    assign wg_rdy[y][0]  = 1'b1;
    assign wg_v[y][NX]   = 1'b0; // East edge.
    assign wg_pkt[y][NX] = '0;
    assign eg_rdy[y][NX] = 1'b1;
  end

  for (genvar x = 0; x < NX; x++) begin : g_ver_edge
    assign sg_v[0][x]       = 1'b0; // North edge.
    assign sg_pkt[0][x]     = '0;
    assign ng_rdy[0][x]     = 1'b1;
    assign ng_v[NY][x]      = ver_s_v_i[x];
    assign ng_pkt[NY][x]    = ver_s_pkt_i[x];
    assign ver_s_ready_o[x] = ng_rdy[NY][x];
    assign ver_s_v_o[x]     = sg_v[NY][x];
    assign ver_s_pkt_o[x]   = sg_pkt[NY][x];
    assign sg_rdy[NY][x]    = ver_s_ready_i[x];
  end

  for (genvar y = 0; y < NY; y++) begin : g_row
    for (genvar x = 0; x < NX; x++) begin : g_col
      logic                  req_v;
      logic                  req_rdy;
      manycore_pkg::packet_t req_pkt;
      logic                  resp_v;
      logic                  resp_rdy;
      manycore_pkg::packet_t resp_pkt;

      mesh_router #(.my_x_p(x), .my_y_p(y)) router (
        .clk_i    (clk_i),        .arst_n_i (arst_n_i),
        .p_v_i    (resp_v),       .p_pkt_i  (resp_pkt),       .p_ready_o (resp_rdy),
        .p_v_o    (req_v),        .p_pkt_o  (req_pkt),        .p_ready_i (req_rdy),
        .n_v_i    (sg_v[y][x]),   .n_pkt_i  (sg_pkt[y][x]),   .n_ready_o (sg_rdy[y][x]),
        .n_v_o    (ng_v[y][x]),   .n_pkt_o  (ng_pkt[y][x]),   .n_ready_i (ng_rdy[y][x]),
        .s_v_i    (ng_v[y+1][x]), .s_pkt_i  (ng_pkt[y+1][x]), .s_ready_o (ng_rdy[y+1][x]),
        .s_v_o    (sg_v[y+1][x]), .s_pkt_o  (sg_pkt[y+1][x]), .s_ready_i (sg_rdy[y+1][x]),
        .e_v_i    (wg_v[y][x+1]), .e_pkt_i  (wg_pkt[y][x+1]), .e_ready_o (wg_rdy[y][x+1]),
        .e_v_o    (eg_v[y][x+1]), .e_pkt_o  (eg_pkt[y][x+1]), .e_ready_i (eg_rdy[y][x+1]),
        .w_v_i    (eg_v[y][x]),   .w_pkt_i  (eg_pkt[y][x]),   .w_ready_o (eg_rdy[y][x]),
        .w_v_o    (wg_v[y][x]),   .w_pkt_o  (wg_pkt[y][x]),   .w_ready_i (wg_rdy[y][x])
      );

      tile_endpoint #(.my_x_p(x), .my_y_p(y)) endpoint (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_v_i      (req_v),
        .req_pkt_i    (req_pkt),
        .req_ready_o  (req_rdy),
        .resp_v_o     (resp_v),
        .resp_pkt_o   (resp_pkt),
        .resp_ready_i (resp_rdy)
      );
    end
  end

endmodule

//--- verilog/manycore_wrapper.sv
/* Top level of the mesh.
   South column CACHE_X is the cache port, column LOADER_X the loader port. */
`timescale 1ns/10ps

module manycore_wrapper (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  cache_v_i,
  input  manycore_pkg::packet_t cache_pkt_i,
  output logic                  cache_ready_o,
  output logic                  cache_v_o,
  output manycore_pkg::packet_t cache_pkt_o,
  input  logic                  cache_ready_i,
  input  logic                  loader_v_i,
  input  manycore_pkg::packet_t loader_pkt_i,
  output logic                  loader_ready_o,
  output logic                  loader_v_o,
  output manycore_pkg::packet_t loader_pkt_o,
  input  logic                  loader_ready_i
);

  logic                  [manycore_pkg::NUM_TILES_X-1:0] ver_s_v_li;
  manycore_pkg::packet_t [manycore_pkg::NUM_TILES_X-1:0] ver_s_pkt_li;
  logic                  [manycore_pkg::NUM_TILES_X-1:0] ver_s_ready_lo;
  logic                  [manycore_pkg::NUM_TILES_X-1:0] ver_s_v_lo;
  manycore_pkg::packet_t [manycore_pkg::NUM_TILES_X-1:0] ver_s_pkt_lo;
  logic                  [manycore_pkg::NUM_TILES_X-1:0] ver_s_ready_li;

  manycore_array array (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .ver_s_v_i     (ver_s_v_li),
    .ver_s_pkt_i   (ver_s_pkt_li),
    .ver_s_ready_o (ver_s_ready_lo),
    .ver_s_v_o     (ver_s_v_lo),
    .ver_s_pkt_o   (ver_s_pkt_lo),
    .ver_s_ready_i (ver_s_ready_li)
  );

  assign ver_s_v_li[manycore_pkg::CACHE_X]     = cache_v_i;
  assign ver_s_pkt_li[manycore_pkg::CACHE_X]   = cache_pkt_i;
  assign ver_s_ready_li[manycore_pkg::CACHE_X] = cache_ready_i;
  assign cache_ready_o = ver_s_ready_lo[manycore_pkg::CACHE_X];
  assign cache_v_o     = ver_s_v_lo[manycore_pkg::CACHE_X];
  assign cache_pkt_o   = ver_s_pkt_lo[manycore_pkg::CACHE_X];

  assign ver_s_v_li[manycore_pkg::LOADER_X]     = loader_v_i;
  assign ver_s_pkt_li[manycore_pkg::LOADER_X]   = loader_pkt_i;
  assign ver_s_ready_li[manycore_pkg::LOADER_X] = loader_ready_i;
  assign loader_ready_o = ver_s_ready_lo[manycore_pkg::LOADER_X];
  assign loader_v_o     = ver_s_v_lo[manycore_pkg::LOADER_X];
  assign loader_pkt_o   = ver_s_pkt_lo[manycore_pkg::LOADER_X];

  // Columns between cache and loader are idle.
  for (genvar i = manycore_pkg::CACHE_X + 1; i < manycore_pkg::LOADER_X; i++) begin : g_tieoff_s
    assign ver_s_v_li[i]     = 1'b0;
    assign ver_s_pkt_li[i]   = '0;
    assign ver_s_ready_li[i] = 1'b1;
  end

endmodule

//--- tb/manycore_assertions.sv
/* Handshake assertions on the mesh wrapper links, bound into the wrapper. */
`timescale 1ns/10ps

module manycore_assertions (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  cache_v_i,
  input manycore_pkg::packet_t cache_pkt_i,
  input logic                  cache_ready_o,
  input logic                  cache_v_o,
  input manycore_pkg::packet_t cache_pkt_o,
  input logic                  cache_ready_i,
  input logic                  loader_v_i,
  input manycore_pkg::packet_t loader_pkt_i,
  input logic                  loader_ready_o,
  input logic                  loader_v_o
);

  int assert_errors = 0;

  cache_out_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cache_v_o && !cache_ready_i |=> cache_v_o && $stable(cache_pkt_o))
    else begin
      $error("cache output changed while stalled");
      assert_errors++;
    end

  cache_in_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cache_v_i && !cache_ready_o |=> cache_v_i && $stable(cache_pkt_i))
    else begin
      $error("cache input changed before it was taken");
      assert_errors++;
    end

  loader_in_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    loader_v_i && !loader_ready_o |=> loader_v_i && $stable(loader_pkt_i))
    else begin
      $error("loader input changed before it was taken");
      assert_errors++;
    end

  reset_quiet_a: assert property (@(posedge clk_i) !arst_n_i |-> !cache_v_o && !loader_v_o)
    else begin
      $error("output valid high during reset");
      assert_errors++;
    end

endmodule

bind manycore_wrapper manycore_assertions asrt0 (.*);

//--- tb/mesh_checker.sv
/* Packet checker: memory model per tile, expected load responses
   and expected cache bound packets, compared at the DUT ports. */
`timescale 1ns/10ps

module mesh_checker (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  cache_v_i,
  input  manycore_pkg::packet_t cache_pkt_i,
  input  logic                  cache_ready_o,
  input  logic                  cache_v_o,
  input  manycore_pkg::packet_t cache_pkt_o,
  input  logic                  cache_ready_i,
  input  logic                  loader_v_i,
  input  manycore_pkg::packet_t loader_pkt_i,
  input  logic                  loader_ready_o,
  input  logic                  loader_v_o,
  input  manycore_pkg::packet_t loader_pkt_o,
  input  logic                  loader_ready_i,
  output int                    errors_o,
  output int                    exp_cache_o,
  output int                    exp_load_o
);

  localparam int NX = manycore_pkg::NUM_TILES_X;
  localparam int NT = manycore_pkg::NUM_TILES_X * manycore_pkg::NUM_TILES_Y;

  manycore_pkg::data_t   mem_m [NT][manycore_pkg::DMEM_WORDS];
  manycore_pkg::packet_t cache_q [$];
  manycore_pkg::packet_t load_q [$];
  manycore_pkg::packet_t exp_pkt;
  int                    err_cnt;

  function automatic void accept(manycore_pkg::packet_t pkt);
    manycore_pkg::x_cord_t dx;
    manycore_pkg::y_cord_t dy;
    manycore_pkg::addr_t   a;
    manycore_pkg::packet_t resp;
    int                    tile;
    dx   = pkt[manycore_pkg::DST_X_LSB +: manycore_pkg::X_CORD_W];
    dy   = pkt[manycore_pkg::DST_Y_LSB +: manycore_pkg::Y_CORD_W];
    a    = pkt[manycore_pkg::ADDR_LSB +: manycore_pkg::ADDR_W];
    tile = int'(dx) + NX * int'(dy);
    if (int'(dy) == manycore_pkg::NUM_TILES_Y) begin
      cache_q.push_back(pkt); // Passes through untouched.
    end else if (pkt[manycore_pkg::OP_LSB] == manycore_pkg::OP_STORE) begin
      mem_m[tile][a] = pkt[manycore_pkg::DATA_LSB +: manycore_pkg::DATA_W];
    end else begin
      resp = '0;
      resp[manycore_pkg::OP_LSB]                              = manycore_pkg::OP_LOAD;
      resp[manycore_pkg::ADDR_LSB +: manycore_pkg::ADDR_W]    = a;
      resp[manycore_pkg::DATA_LSB +: manycore_pkg::DATA_W]    = mem_m[tile][a];
      resp[manycore_pkg::DST_X_LSB +: manycore_pkg::X_CORD_W] =
        pkt[manycore_pkg::SRC_X_LSB +: manycore_pkg::X_CORD_W];
      resp[manycore_pkg::DST_Y_LSB +: manycore_pkg::Y_CORD_W] =
        pkt[manycore_pkg::SRC_Y_LSB +: manycore_pkg::Y_CORD_W];
      resp[manycore_pkg::SRC_X_LSB +: manycore_pkg::X_CORD_W] = dx;
      resp[manycore_pkg::SRC_Y_LSB +: manycore_pkg::Y_CORD_W] = dy;
      load_q.push_back(resp);
    end
  endfunction

  function automatic void report_mismatch(string name, manycore_pkg::packet_t exp,
      manycore_pkg::packet_t act);
    $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    err_cnt++;
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int t = 0; t < NT; t++) begin
        for (int w = 0; w < manycore_pkg::DMEM_WORDS; w++) begin
          mem_m[t][w] = '0;
        end
      end
      cache_q.delete();
      load_q.delete();
      err_cnt = 0;
    end else begin
      if (cache_v_i && cache_ready_o)
        accept(cache_pkt_i);
      if (loader_v_i && loader_ready_o)
        accept(loader_pkt_i);
      if (cache_v_o && cache_ready_i) begin
        if (cache_q.size() == 0) begin
          $display("Error: cache port delivered a packet nobody sent: %h", cache_pkt_o);
          err_cnt++;
        end else begin
          exp_pkt = cache_q.pop_front();
          if (exp_pkt !== cache_pkt_o)
            report_mismatch("cache_out", exp_pkt, cache_pkt_o);
        end
      end
      if (loader_v_o && loader_ready_i) begin
        if (load_q.size() == 0) begin
          $display("Error: loader port got a response to no load: %h", loader_pkt_o);
          err_cnt++;
        end else begin
          exp_pkt = load_q.pop_front();
          if (exp_pkt !== loader_pkt_o)
            report_mismatch("loader_resp", exp_pkt, loader_pkt_o);
        end
      end
    end
    errors_o    = err_cnt;
    exp_cache_o = cache_q.size();
    exp_load_o  = load_q.size();
  end

endmodule

//--- tb/tb_top.sv
/* Mesh testbench top: clock, reset, LFSR driven loader and cache agents,
   the DUT, the packet checker and the closing report. */
`timescale 1ns/10ps

module tb_top;

  localparam int TIMEOUT = 500;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  cache_v_i;
  manycore_pkg::packet_t cache_pkt_i;
  logic                  cache_ready_o;
  logic                  cache_v_o;
  manycore_pkg::packet_t cache_pkt_o;
  logic                  cache_ready_i;
  logic                  loader_v_i;
  manycore_pkg::packet_t loader_pkt_i;
  logic                  loader_ready_o;
  logic                  loader_v_o;
  manycore_pkg::packet_t loader_pkt_o;
  logic                  loader_ready_i;

  logic [31:0] lfsr_q;
  logic        load_busy;
  logic        timed_out;
  logic        c_fire;
  logic        l_fire;
  int          load_idx;
  int          cache_wait;
  int          loader_wait;
  int          load_wait;
  int          guard;
  int          tb_errors;
  int          chk_errors;
  int          exp_cache_cnt;
  int          exp_load_cnt;

  manycore_wrapper dut0 (.*);

  mesh_checker chk0 (
    .clk_i, .arst_n_i,
    .cache_v_i, .cache_pkt_i, .cache_ready_o, .cache_v_o, .cache_pkt_o, .cache_ready_i,
    .loader_v_i, .loader_pkt_i, .loader_ready_o, .loader_v_o, .loader_pkt_o, .loader_ready_i,
    .errors_o    (chk_errors),
    .exp_cache_o (exp_cache_cnt),
    .exp_load_o  (exp_load_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit taken.
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic manycore_pkg::packet_t make_pkt(logic op, manycore_pkg::addr_t addr,
      manycore_pkg::data_t data, manycore_pkg::x_cord_t dx, manycore_pkg::y_cord_t dy,
      manycore_pkg::x_cord_t sx, manycore_pkg::y_cord_t sy);
    manycore_pkg::packet_t p;
    p = '0;
    p[manycore_pkg::OP_LSB]                              = op;
    p[manycore_pkg::ADDR_LSB +: manycore_pkg::ADDR_W]    = addr;
    p[manycore_pkg::DATA_LSB +: manycore_pkg::DATA_W]    = data;
    p[manycore_pkg::DST_X_LSB +: manycore_pkg::X_CORD_W] = dx;
    p[manycore_pkg::DST_Y_LSB +: manycore_pkg::Y_CORD_W] = dy;
    p[manycore_pkg::SRC_X_LSB +: manycore_pkg::X_CORD_W] = sx;
    p[manycore_pkg::SRC_Y_LSB +: manycore_pkg::Y_CORD_W] = sy;
    return p;
  endfunction

  task automatic note_timeout(string what);
    $display("Error: timed out waiting for %s", what);
    tb_errors++;
    timed_out = 1'b1;
  endtask

  task automatic drive_loader(logic op, manycore_pkg::addr_t addr, manycore_pkg::data_t data,
      manycore_pkg::x_cord_t dx, manycore_pkg::y_cord_t dy);
    loader_pkt_i = make_pkt(op, addr, data, dx, dy, manycore_pkg::LOADER_X,
                            manycore_pkg::LOADER_Y);
    loader_v_i   = 1'b1;
    if (op == manycore_pkg::OP_LOAD && dy != manycore_pkg::LOADER_Y)
      load_busy = 1'b1; // One load in flight.
  endtask

  // Phase 1 zero loads, 2 random traffic, 3 read back cache stores, 0 idle.
  task automatic agent_cycle(int phase);
    logic [1:0] sel;
    logic [4:0] idx;
    @(posedge clk_i);
    c_fire = cache_v_i && cache_ready_o;
    l_fire = loader_v_i && loader_ready_o;
    if (loader_v_o)
      load_busy = 1'b0;
    #1;
    cache_ready_i = (rand_bits(2) != 32'd0);
    if (c_fire)
      cache_v_i = 1'b0;
    if (l_fire)
      loader_v_i = 1'b0;
    cache_wait  = cache_v_i ? cache_wait + 1 : 0;
    loader_wait = loader_v_i ? loader_wait + 1 : 0;
    load_wait   = load_busy ? load_wait + 1 : 0;
    if (cache_wait > TIMEOUT)
      note_timeout("cache_ready_o");
    if (loader_wait > TIMEOUT)
      note_timeout("loader_ready_o");
    if (load_wait > TIMEOUT)
      note_timeout("a load response");
    if (phase == 2 && !cache_v_i && rand_bits(2) == 32'd0) begin
      cache_pkt_i = make_pkt(manycore_pkg::OP_STORE, {1'b1, 3'(rand_bits(3))},
                             16'(rand_bits(16)), 1'(rand_bits(1)),
                             {1'b0, 1'(rand_bits(1))},
                             manycore_pkg::CACHE_X, manycore_pkg::CACHE_Y);
      cache_v_i   = 1'b1;
    end
    if (!loader_v_i && !load_busy) begin
      idx = load_idx[4:0];
      if (phase == 1 && load_idx < 8) begin
        drive_loader(manycore_pkg::OP_LOAD, 4'(rand_bits(4)), '0, idx[0], {1'b0, idx[1]});
        load_idx++;
      end else if (phase == 3 && load_idx < 32) begin
        drive_loader(manycore_pkg::OP_LOAD, {1'b1, idx[4:2]}, '0, idx[0], {1'b0, idx[1]});
        load_idx++;
      end else if (phase == 2 && rand_bits(1) == 32'd1) begin
        sel = 2'(rand_bits(2));
        if (sel == 2'd0)
          drive_loader(1'(rand_bits(1)), 4'(rand_bits(4)), 16'(rand_bits(16)),
                       manycore_pkg::CACHE_X, manycore_pkg::CACHE_Y);
        else
          drive_loader(sel == 2'd1, {1'b0, 3'(rand_bits(3))}, 16'(rand_bits(16)),
                       1'(rand_bits(1)), {1'b0, 1'(rand_bits(1))});
      end
    end
  endtask

  task automatic drain(string what);
    guard = 0;
    while (!timed_out && (exp_cache_cnt != 0 || exp_load_cnt != 0 || load_busy ||
           cache_v_i || loader_v_i)) begin
      agent_cycle(0);
      guard++;
      if (guard > 4 * TIMEOUT)
        note_timeout(what);
    end
  endtask

  initial begin
    lfsr_q         = 32'h195b_3fc1;
    arst_n_i       = 1'b0;
    cache_v_i      = 1'b0;
    cache_pkt_i    = '0;
    cache_ready_i  = 1'b1;
    loader_v_i     = 1'b0;
    loader_pkt_i   = '0;
    loader_ready_i = 1'b1; // Loader side always ready.
    load_busy      = 1'b0;
    timed_out      = 1'b0;
    tb_errors      = 0;
    cache_wait     = 0;
    loader_wait    = 0;
    load_wait      = 0;
    repeat (3) @(posedge clk_i);
    #1 arst_n_i = 1'b1;

    load_idx = 0;
    while (!timed_out && load_idx < 8)
      agent_cycle(1);
    drain("the zero loads to finish");
    for (int i = 0; i < 400 && !timed_out; i++)
      agent_cycle(2);
    drain("random traffic to drain");
    for (int i = 0; i < 40 && !timed_out; i++)
      agent_cycle(0); // Let cache stores land.
    load_idx = 0;
    while (!timed_out && load_idx < 32)
      agent_cycle(3);
    drain("the read back loads to finish");

    $display("Errors: checker %0d, testbench %0d, assertions %0d",
             chk_errors, tb_errors, dut0.asrt0.assert_errors);
    if (chk_errors + tb_errors + dut0.asrt0.assert_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    #2_000_000;
    $display("Error: simulation ran past its overall time limit");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- tb.f
verilog/manycore_pkg.sv
verilog/mesh_router.sv
verilog/tile_endpoint.sv
verilog/manycore_array.sv
verilog/manycore_wrapper.sv
tb/manycore_assertions.sv
tb/mesh_checker.sv
tb/tb_top.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the mesh testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o Vtb_top
	./obj_dir/Vtb_top +verilator+error+limit+100 | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
